// ==== decodeCore.f ====
rtl/isaPkg.sv
rtl/ctlPkg.sv
rtl/programFetch.sv
rtl/wordQueue.sv
rtl/instrDecode.sv
rtl/decodeCore.sv
sim/decodeCoreTb.sv

// ==== rtl/ctlPkg.sv ====
// Control codes for the datapath; jump conditions take the low codes 0..7, so ALU codes start at 8
`default_nettype none

package ctlPkg;

   // Function-select code
   typedef logic [5:0] fs_t;

   // Invalid or unknown opcode
   localparam fs_t FS_NONE = 6'd0;

   // Format I functions
   localparam fs_t FS_MOV  = 6'd8;
   localparam fs_t FS_ADD  = 6'd9;
   localparam fs_t FS_ADDC = 6'd10;
   localparam fs_t FS_SUBC = 6'd11;
   localparam fs_t FS_SUB  = 6'd12;
   localparam fs_t FS_CMP  = 6'd13;
   localparam fs_t FS_DADD = 6'd14;
   localparam fs_t FS_BIT  = 6'd15;
   localparam fs_t FS_BIC  = 6'd16;
   localparam fs_t FS_BIS  = 6'd17;
   localparam fs_t FS_XOR  = 6'd18;
   localparam fs_t FS_AND  = 6'd19;

   // Format II functions
   localparam fs_t FS_RRC  = 6'd20;
   localparam fs_t FS_SWPB = 6'd21;
   localparam fs_t FS_RRA  = 6'd22;
   localparam fs_t FS_SXT  = 6'd23;
   localparam fs_t FS_PUSH = 6'd24;
   localparam fs_t FS_CALL = 6'd25;
   localparam fs_t FS_RETI = 6'd26;

   // Extension words after an opcode, 0 to 2
   typedef logic [1:0] extCount_t;

   // Decoder expects an opcode or an extension word
   typedef enum logic
   {
      DS_OPCODE = 1'b0,
      DS_EXT    = 1'b1
   } decState_t;

endpackage

`default_nettype wire

// ==== rtl/decodeCore.sv ====
// Front end only; memory latency must be 1 cycle, and QueueDepth of 2 or more, power of two
`default_nettype none

module decodeCore
#(
   parameter int QueueDepth = 4,
   parameter isaPkg::addr_t ResetAddr = 16'h0000
)
(
   input  logic              clk,
   input  logic              reset,
   input  logic              hold,
   input  isaPkg::word_t     memData,
   output isaPkg::addr_t     memAddr,
   output logic              memRead,
   output logic              redirect,
   output isaPkg::addr_t     redirectAddr,
   output logic              decValid,
   output isaPkg::format_t   format,
   output ctlPkg::fs_t       fs,
   output logic              rw,
   output logic              bw,
   output isaPkg::reg_t      srcReg,
   output isaPkg::reg_t      dstReg,
   output logic [2:0]        adAs,
   output ctlPkg::extCount_t extWords,
   output logic              extValid,
   output isaPkg::word_t     extData
);

   // Fetch to queue
   logic          wordValid;
   isaPkg::word_t word;
   logic          queueFull;
   // Queue to decoder
   isaPkg::word_t headWord;
   logic          empty;
   logic          pop;

   programFetch #(.QueueDepth(QueueDepth), .ResetAddr(ResetAddr)) fetch0 (
      .clk(clk), .reset(reset), .queueFull(queueFull), .pop(pop),
      .redirect(redirect), .redirectAddr(redirectAddr), .memData(memData),
      .memAddr(memAddr), .memRead(memRead), .wordValid(wordValid), .word(word)
   );

   // Jump redirect also flushes the queue
   wordQueue #(.QueueDepth(QueueDepth)) queue0 (
      .clk(clk), .reset(reset), .push(wordValid), .pushWord(word), .pop(pop),
      .flush(redirect), .headWord(headWord), .empty(empty), .full(queueFull)
   );

   instrDecode #(.ResetAddr(ResetAddr)) decode0 (
      .clk(clk), .reset(reset), .headWord(headWord), .empty(empty), .hold(hold),
      .pop(pop), .redirect(redirect), .redirectAddr(redirectAddr),
      .decValid(decValid), .format(format), .fs(fs), .rw(rw), .bw(bw),
      .srcReg(srcReg), .dstReg(dstReg), .adAs(adAs), .extWords(extWords),
      .extValid(extValid), .extData(extData)
   );

endmodule

`default_nettype wire

// ==== rtl/instrDecode.sv ====
// Every jump counts as taken; Ad extension rules apply to format I only, no constant generator beyond R0
`default_nettype none

module instrDecode
#(
   parameter isaPkg::addr_t ResetAddr = 16'h0000
)
(
   input  logic               clk,
   input  logic               reset,
   input  isaPkg::word_t      headWord,
   input  logic               empty,
   input  logic               hold,
   output logic               pop,
   output logic               redirect,
   output isaPkg::addr_t      redirectAddr,
   output logic               decValid,
   output isaPkg::format_t    format,
   output ctlPkg::fs_t        fs,
   output logic               rw,
   output logic               bw,
   output isaPkg::reg_t       srcReg,
   output isaPkg::reg_t       dstReg,
   output logic [2:0]         adAs,
   output ctlPkg::extCount_t  extWords,
   output logic               extValid,
   output isaPkg::word_t      extData
);

   ctlPkg::decState_t state;
   ctlPkg::extCount_t remain;
   // Address of the word now at the queue head
   isaPkg::addr_t headAddr;

   isaPkg::format_t   fmtNext;
   ctlPkg::fs_t       fsNext;
   logic              rwNext;
   ctlPkg::extCount_t extNext;
   isaPkg::addr_t     jumpTarget;

   // Words at the head after a jump are stale until the flush lands
   assign pop = !empty && !hold && !redirect;

   // PC-relative target: next word plus twice the signed 10-bit offset
   assign jumpTarget = headAddr + 16'd2 + {{5{headWord[9]}}, headWord[9:0], 1'b0};

   // Instruction class
   always_comb
   begin
      if (headWord[15:13] == isaPkg::OP_JUMP)
         fmtNext = isaPkg::FMT_J;
      else if (headWord[15:12] == isaPkg::FMT_II_PREFIX)
         fmtNext = isaPkg::FMT_II;
      else if (headWord[15:12] >= isaPkg::FMT_I_MIN)
         fmtNext = isaPkg::FMT_I;
      else
         fmtNext = isaPkg::FMT_NONE;
   end

   // Function select and register write
   always_comb
   begin
      fsNext = ctlPkg::FS_NONE;
      rwNext = 1'b1;
      case (fmtNext)
         isaPkg::FMT_I:
            case (headWord[15:12])
               isaPkg::OP_MOV:  fsNext = ctlPkg::FS_MOV;
               isaPkg::OP_ADD:  fsNext = ctlPkg::FS_ADD;
               isaPkg::OP_ADDC: fsNext = ctlPkg::FS_ADDC;
               isaPkg::OP_SUBC: fsNext = ctlPkg::FS_SUBC;
               isaPkg::OP_SUB:  fsNext = ctlPkg::FS_SUB;
               isaPkg::OP_DADD: fsNext = ctlPkg::FS_DADD;
               isaPkg::OP_BIC:  fsNext = ctlPkg::FS_BIC;
               isaPkg::OP_BIS:  fsNext = ctlPkg::FS_BIS;
               isaPkg::OP_XOR:  fsNext = ctlPkg::FS_XOR;
               isaPkg::OP_AND:  fsNext = ctlPkg::FS_AND;
               // Compare and bit test only set flags
               isaPkg::OP_CMP:
               begin
                  fsNext = ctlPkg::FS_CMP;
                  rwNext = 1'b0;
               end
               isaPkg::OP_BIT:
               begin
                  fsNext = ctlPkg::FS_BIT;
                  rwNext = 1'b0;
               end
               default: rwNext = 1'b0;
            endcase
         isaPkg::FMT_II:
            case (headWord[15:7])
               isaPkg::OP_RRC:  fsNext = ctlPkg::FS_RRC;
               isaPkg::OP_SWPB: fsNext = ctlPkg::FS_SWPB;
               isaPkg::OP_RRA:  fsNext = ctlPkg::FS_RRA;
               isaPkg::OP_SXT:  fsNext = ctlPkg::FS_SXT;
               isaPkg::OP_PUSH: fsNext = ctlPkg::FS_PUSH;
               isaPkg::OP_CALL: fsNext = ctlPkg::FS_CALL;
               isaPkg::OP_RETI: fsNext = ctlPkg::FS_RETI;
               default: rwNext = 1'b0;
            endcase
         // Condition field becomes the code
         isaPkg::FMT_J:
         begin
            fsNext = ctlPkg::fs_t'({3'b000, headWord[12:10]});
            rwNext = 1'b0;
         end
         default: rwNext = 1'b0;
      endcase
   end

   // Extension words from As, Ad and the source register
   always_comb
   begin
      extNext = 2'd0;
      if (fmtNext == isaPkg::FMT_I || fmtNext == isaPkg::FMT_II)
      begin
         case (headWord[5:4])
            // Indexed source, plus one more for indexed destination
            2'b01: extNext = (fmtNext == isaPkg::FMT_I && headWord[7]) ? 2'd2 : 2'd1;
            // Immediate when the source is R0, else autoincrement
            2'b11: extNext = (fmtNext == isaPkg::FMT_I && headWord[11:8] == 4'd0) ? 2'd1 : 2'd0;
            default: extNext = (fmtNext == isaPkg::FMT_I && headWord[7]) ? 2'd1 : 2'd0;
         endcase
      end
   end

   // Decoded fields, loaded on an opcode pop
   always_ff @(posedge clk)
   begin
      if (pop && state == ctlPkg::DS_OPCODE)
      begin
         format       <= fmtNext;
         fs           <= fsNext;
         rw           <= rwNext;
         extWords     <= extNext;
         redirectAddr <= jumpTarget;
         bw     <= (fmtNext == isaPkg::FMT_I || fmtNext == isaPkg::FMT_II) ? headWord[6] : 1'b0;
         srcReg <= (fmtNext == isaPkg::FMT_I) ? headWord[11:8] : 4'd0;
         dstReg <= (fmtNext == isaPkg::FMT_I || fmtNext == isaPkg::FMT_II) ? headWord[3:0] : 4'd0;
         adAs[2]   <= (fmtNext == isaPkg::FMT_I) ? headWord[7] : 1'b0;
         adAs[1:0] <= (fmtNext == isaPkg::FMT_I || fmtNext == isaPkg::FMT_II) ?
                      headWord[5:4] : 2'b00;
      end
      // Extension word passes through untouched
      if (pop && state == ctlPkg::DS_EXT)
         extData <= headWord;
   end

   // Sequencing, head address and strobes
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= ctlPkg::DS_OPCODE;
         remain   <= 2'd0;
         headAddr <= ResetAddr;
         decValid <= 1'b0;
         extValid <= 1'b0;
         redirect <= 1'b0;
      end
      else
      begin
         decValid <= pop && state == ctlPkg::DS_OPCODE;
         extValid <= pop && state == ctlPkg::DS_EXT;
         redirect <= pop && state == ctlPkg::DS_OPCODE && fmtNext == isaPkg::FMT_J;
         if (redirect)
            headAddr <= redirectAddr;
         else if (pop)
            headAddr <= headAddr + 16'd2;
         if (pop)
         begin
            if (state == ctlPkg::DS_OPCODE)
            begin
               remain <= extNext;
               if (extNext != 2'd0)
                  state <= ctlPkg::DS_EXT;
            end
            else
            begin
               remain <= remain - 2'd1;
               // Last extension word ends the instruction
               if (remain == 2'd1)
                  state <= ctlPkg::DS_OPCODE;
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== rtl/isaPkg.sv ====
// Encoding of the MSP430-style subset only; byte addresses, words are 16 bits and word aligned
`default_nettype none

package isaPkg;

   // Instruction and memory data word
   typedef logic [15:0] word_t;

   // Byte address, bit 0 stays zero for program words
   typedef logic [15:0] addr_t;

   // Register number R0..R15
   typedef logic [3:0] reg_t;

   // Instruction class of an opcode word
   typedef enum logic [1:0]
   {
      FMT_NONE = 2'd0,
      FMT_I    = 2'd1,
      FMT_II   = 2'd2,
      FMT_J    = 2'd3
   } format_t;

   // Class prefixes on the top bits of the word
   localparam logic [2:0] OP_JUMP       = 3'b001;
   localparam logic [3:0] FMT_II_PREFIX = 4'b0001;
   // Format I occupies every top nibble from here upward
   localparam logic [3:0] FMT_I_MIN     = 4'b0100;

   // Format I opcodes, bits 15:12
   localparam logic [3:0] OP_MOV  = 4'h4;
   localparam logic [3:0] OP_ADD  = 4'h5;
   localparam logic [3:0] OP_ADDC = 4'h6;
   localparam logic [3:0] OP_SUBC = 4'h7;
   localparam logic [3:0] OP_SUB  = 4'h8;
   localparam logic [3:0] OP_CMP  = 4'h9;
   localparam logic [3:0] OP_DADD = 4'hA;
   localparam logic [3:0] OP_BIT  = 4'hB;
   localparam logic [3:0] OP_BIC  = 4'hC;
   localparam logic [3:0] OP_BIS  = 4'hD;
   localparam logic [3:0] OP_XOR  = 4'hE;
   localparam logic [3:0] OP_AND  = 4'hF;

   // Format II opcodes, bits 15:7
   localparam logic [8:0] OP_RRC  = 9'h020;
   localparam logic [8:0] OP_SWPB = 9'h021;
   localparam logic [8:0] OP_RRA  = 9'h022;
   localparam logic [8:0] OP_SXT  = 9'h023;
   localparam logic [8:0] OP_PUSH = 9'h024;
   localparam logic [8:0] OP_CALL = 9'h025;
   localparam logic [8:0] OP_RETI = 9'h026;

endpackage

`default_nettype wire

// ==== rtl/programFetch.sv ====
// Memory must answer with fixed latency 1; QueueDepth must match the queue fed by word
`default_nettype none

module programFetch
#(
   parameter int QueueDepth = 4,
   parameter isaPkg::addr_t ResetAddr = 16'h0000
)
(
   input  logic          clk,
   input  logic          reset,
   input  logic          queueFull,
   input  logic          pop,
   input  logic          redirect,
   input  isaPkg::addr_t redirectAddr,
   input  isaPkg::word_t memData,
   output isaPkg::addr_t memAddr,
   output logic          memRead,
   output logic          wordValid,
   output isaPkg::word_t word
);

   localparam int CreditW = $clog2(QueueDepth + 1);

   // Words queued or still in flight
   logic [CreditW-1:0] credit;
   logic [CreditW-1:0] creditNext;
   isaPkg::addr_t pc;

   // Returned data goes straight to the queue
   assign memAddr = pc;
   assign word    = memData;

   // Redirect empties the queue and drops the read issued now
   always_comb
   begin
      creditNext = credit;
      if (redirect)
         creditNext = '0;
      else if (memRead && !pop)
         creditNext = credit + 1'b1;
      else if (!memRead && pop)
         creditNext = credit - 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         pc        <= ResetAddr;
         credit    <= '0;
         memRead   <= 1'b0;
         wordValid <= 1'b0;
      end
      else
      begin
         credit <= creditNext;
         // Keep one slot spare so a returning word always fits
         memRead <= !queueFull && (creditNext < CreditW'(QueueDepth - 1));
         // The single read in flight; stale if issued during a redirect
         wordValid <= memRead && !redirect;
         if (redirect)
            pc <= redirectAddr;
         else if (memRead)
            pc <= pc + 16'd2;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/wordQueue.sv ====
// Circular FIFO of program words; push while full without a pop is dropped, flush beats push
`default_nettype none

module wordQueue
#(
   parameter int QueueDepth = 4
)
(
   input  logic          clk,
   input  logic          reset,
   input  logic          push,
   input  isaPkg::word_t pushWord,
   input  logic          pop,
   input  logic          flush,
   output isaPkg::word_t headWord,
   output logic          empty,
   output logic          full
);

   localparam int PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
   localparam int CntW = $clog2(QueueDepth + 1);

   isaPkg::word_t mem [QueueDepth];
   logic [PtrW-1:0] rdPtr;
   logic [PtrW-1:0] wrPtr;
   logic [CntW-1:0] count;
   logic doPush;
   logic doPop;

   // Push into a full queue only if the head leaves at the same edge
   assign doPush = push && !flush && (!full || pop);
   assign doPop  = pop && !empty && !flush;

   assign headWord = mem[rdPtr];
   assign empty    = (count == '0);
   assign full     = (count == CntW'(QueueDepth));

   // Storage
   always_ff @(posedge clk)
   begin
      if (doPush)
         mem[wrPtr] <= pushWord;
   end

   // Pointers and occupancy
   always_ff @(posedge clk)
   begin
      if (reset || flush)
      begin
         rdPtr <= '0;
         wrPtr <= '0;
         count <= '0;
      end
      else
      begin
         if (doPush)
            wrPtr <= (wrPtr == PtrW'(QueueDepth - 1)) ? '0 : wrPtr + 1'b1;
         if (doPop)
            rdPtr <= (rdPtr == PtrW'(QueueDepth - 1)) ? '0 : rdPtr + 1'b1;
         // Simultaneous push and pop leave the count alone
         if (doPush && !doPop)
            count <= count + 1'b1;
         else if (doPop && !doPush)
            count <= count - 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; exit status follows the simulation
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f decodeCore.f --top-module decodeCoreTb -o decodeCoreSim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit $status
fi

./obj_dir/decodeCoreSim
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation failed with status $status"
   exit $status
fi
exit 0

// ==== sim/decodeCoreTb.sv ====
// Memory model answers one cycle after memRead; every jump counts as taken; stops at first error
`default_nettype none

module decodeCoreTb;

   localparam int NumRecords = 32;
   localparam int ProgWords  = 47;
   localparam int MemWords   = 256;
   localparam int Timeout    = 200;

   // Program image from byte address 0, eight words per row
   localparam isaPkg::word_t Program [ProgWords] = '{
      16'h4506, 16'h5344, 16'h6102, 16'h7708, 16'h890A, 16'h9B0C, 16'hAD0E, 16'hBF41,
      16'hC203, 16'hD405, 16'hE607, 16'hF809, 16'h1004, 16'h1085, 16'h1146, 16'h11A7,
      16'h1208, 16'h1299, 16'h1234, 16'h1300, 16'h4596, 16'h0002, 16'h0004, 16'h4037,
      16'hBEEF, 16'h5536, 16'h8489, 16'h0006, 16'hF3A2, 16'h0008, 16'hE113, 16'h0010,
      // Invalid word, jump at 0x42, three skipped words, jump at 0x4A
      16'h0A5A, 16'h3C03, 16'h4111, 16'h4222, 16'h4333, 16'h2007, 16'h4444, 16'h4555,
      // 0x50 is the backward target, 0x52 jumps to itself
      16'h1041, 16'h3FFF, 16'h4666, 16'h4777, 16'h4888, 16'h9243, 16'h2FF9
   };

   logic clk = 1'b0;
   logic reset;
   logic hold;
   isaPkg::word_t memData = 16'h0000;
   isaPkg::addr_t memAddr;
   logic memRead;
   logic redirect;
   isaPkg::addr_t redirectAddr;
   logic decValid;
   isaPkg::format_t format;
   ctlPkg::fs_t fs;
   logic rw;
   logic bw;
   isaPkg::reg_t srcReg;
   isaPkg::reg_t dstReg;
   logic [2:0] adAs;
   ctlPkg::extCount_t extWords;
   logic extValid;
   isaPkg::word_t extData;

   // Memory model
   isaPkg::word_t mem [MemWords];
   logic pendRead = 1'b0;
   isaPkg::addr_t pendAddr = 16'h0000;

   // Expected decode records
   isaPkg::format_t expFmt [NumRecords];
   ctlPkg::fs_t expFs [NumRecords];
   logic expRw [NumRecords];
   logic expBw [NumRecords];
   isaPkg::reg_t expSrc [NumRecords];
   isaPkg::reg_t expDst [NumRecords];
   logic [2:0] expModes [NumRecords];
   ctlPkg::extCount_t expExt [NumRecords];
   isaPkg::word_t expData [NumRecords][2];
   isaPkg::addr_t expTarget [NumRecords];
   int recCount;
   int extLoaded;

   int seed = 32'h7456_7a79;
   logic holdRandom;

   always #50 clk = ~clk;

   decodeCore #(.QueueDepth(4), .ResetAddr(16'h0000)) dut0 (
      .clk(clk), .reset(reset), .hold(hold), .memData(memData), .memAddr(memAddr),
      .memRead(memRead), .redirect(redirect), .redirectAddr(redirectAddr),
      .decValid(decValid), .format(format), .fs(fs), .rw(rw), .bw(bw),
      .srcReg(srcReg), .dstReg(dstReg), .adAs(adAs), .extWords(extWords),
      .extValid(extValid), .extData(extData)
   );

   // Answer the read of the previous cycle, so data is stable when wordValid is high
   always @(negedge clk)
   begin
      if (pendRead)
         memData <= mem[pendAddr[8:1]];
      pendRead <= memRead;
      pendAddr <= memAddr;
   end

   task automatic abortRun(string why);
      $display("%s", why);
      $display("STATUS: FAIL");
      $fatal(1);
   endtask

   task automatic checkFormat(string name, isaPkg::format_t exp, isaPkg::format_t got);
      if (got !== exp)
         abortRun($sformatf("error at %0t: %s expected %0d got %0d", $time, name, exp, got));
   endtask

   task automatic verifyFs(string name, ctlPkg::fs_t exp, ctlPkg::fs_t got);
      if (got !== exp)
         abortRun($sformatf("error at %0t: %s expected %0d got %0d", $time, name, exp, got));
   endtask

   task automatic compareReg(string name, isaPkg::reg_t exp, isaPkg::reg_t got);
      if (got !== exp)
         abortRun($sformatf("error at %0t: %s expected %0d got %0d", $time, name, exp, got));
   endtask

   task automatic matchCount(string name, ctlPkg::extCount_t exp, ctlPkg::extCount_t got);
      if (got !== exp)
         abortRun($sformatf("error at %0t: %s expected %0d got %0d", $time, name, exp, got));
   endtask

   task automatic testWord(string name, isaPkg::word_t exp, isaPkg::word_t got);
      if (got !== exp)
         abortRun($sformatf("error at %0t: %s expected %h got %h", $time, name, exp, got));
   endtask

   task automatic confirmAddr(string name, isaPkg::addr_t exp, isaPkg::addr_t got);
      if (got !== exp)
         abortRun($sformatf("error at %0t: %s expected %h got %h", $time, name, exp, got));
   endtask

   task automatic flagEquals(string name, logic exp, logic got);
      if (got !== exp)
         abortRun($sformatf("error at %0t: %s expected %b got %b", $time, name, exp, got));
   endtask

   task automatic modesEqual(string name, logic [2:0] exp, logic [2:0] got);
      if (got !== exp)
         abortRun($sformatf("error at %0t: %s expected %b got %b", $time, name, exp, got));
   endtask

   task automatic addRecord(isaPkg::format_t f, ctlPkg::fs_t c, logic w, logic b,
                            isaPkg::reg_t s, isaPkg::reg_t d, logic [2:0] m,
                            ctlPkg::extCount_t n);
      expFmt[recCount]    = f;
      expFs[recCount]     = c;
      expRw[recCount]     = w;
      expBw[recCount]     = b;
      expSrc[recCount]    = s;
      expDst[recCount]    = d;
      expModes[recCount]  = m;
      expExt[recCount]    = n;
      expTarget[recCount] = 16'h0000;
      recCount  = recCount + 1;
      extLoaded = 0;
   endtask

   // Extension word of the last record added
   task automatic addExt(isaPkg::word_t w);
      expData[recCount - 1][extLoaded] = w;
      extLoaded = extLoaded + 1;
   endtask

   task automatic addTarget(isaPkg::addr_t a);
      expTarget[recCount - 1] = a;
   endtask

   // One cycle; sample at the falling edge, then drive hold
   task automatic nextCycle();
      int rnd;
      begin
         @(negedge clk);
         // A strobe comes from a pop one cycle back, and hold blocks pops
         if ((decValid || extValid) && hold)
            abortRun("decode output appeared after a cycle with hold high");
         rnd = $random(seed);
         hold = holdRandom && rnd[0];
      end
   endtask

   task automatic awaitStrobe();
      int n;
      begin
         n = 0;
         nextCycle();
         while (!decValid && !extValid)
         begin
            n = n + 1;
            if (n > Timeout)
               abortRun("no decode output within the timeout");
            nextCycle();
         end
      end
   endtask

   // First read after the jump must be the target, and nothing decodes meanwhile
   task automatic followRedirect(isaPkg::addr_t target);
      int n;
      begin
         n = 0;
         nextCycle();
         while (!memRead)
         begin
            n = n + 1;
            if (n > Timeout)
               abortRun("no memory read after the jump within the timeout");
            if (decValid || extValid)
               abortRun("decode output before the jump target was fetched");
            nextCycle();
         end
         if (decValid || extValid)
            abortRun("decode output before the jump target was fetched");
         confirmAddr("memAddr", target, memAddr);
      end
   endtask

   task automatic inspectRecord(int r);
      int e;
      begin
         awaitStrobe();
         if (!decValid)
            abortRun($sformatf("record %0d: extension word in place of an opcode", r));
         checkFormat("format", expFmt[r], format);
         verifyFs("fs", expFs[r], fs);
         flagEquals("rw", expRw[r], rw);
         flagEquals("bw", expBw[r], bw);
         compareReg("srcReg", expSrc[r], srcReg);
         compareReg("dstReg", expDst[r], dstReg);
         modesEqual("adAs", expModes[r], adAs);
         matchCount("extWords", expExt[r], extWords);
         flagEquals("redirect", expFmt[r] == isaPkg::FMT_J, redirect);
         if (expFmt[r] == isaPkg::FMT_J)
         begin
            confirmAddr("redirectAddr", expTarget[r], redirectAddr);
            followRedirect(expTarget[r]);
         end
         // Extension words follow their opcode directly
         for (e = 0; e < int'(expExt[r]); e++)
         begin
            awaitStrobe();
            if (!extValid)
               abortRun($sformatf("record %0d: opcode in place of extension word %0d", r, e));
            testWord("extData", expData[r][e], extData);
         end
      end
   endtask

   initial
   begin
      int i;
      int pass;
      int r;
      reset      = 1'b1;
      hold       = 1'b0;
      holdRandom = 1'b0;
      recCount   = 0;
      extLoaded  = 0;
      // Unused memory decodes as invalid, each word tied to its address
      for (i = 0; i < MemWords; i++)
         mem[i] = 16'h0C00 ^ isaPkg::word_t'(i);
      for (i = 0; i < ProgWords; i++)
         mem[i] = Program[i];

      // Register-mode format I
      addRecord(isaPkg::FMT_I, ctlPkg::FS_MOV, 1'b1, 1'b0, 4'd5, 4'd6, 3'b000, 2'd0);
      addRecord(isaPkg::FMT_I, ctlPkg::FS_ADD, 1'b1, 1'b1, 4'd3, 4'd4, 3'b000, 2'd0);
      addRecord(isaPkg::FMT_I, ctlPkg::FS_ADDC, 1'b1, 1'b0, 4'd1, 4'd2, 3'b000, 2'd0);
      addRecord(isaPkg::FMT_I, ctlPkg::FS_SUBC, 1'b1, 1'b0, 4'd7, 4'd8, 3'b000, 2'd0);
      addRecord(isaPkg::FMT_I, ctlPkg::FS_SUB, 1'b1, 1'b0, 4'd9, 4'd10, 3'b000, 2'd0);
      addRecord(isaPkg::FMT_I, ctlPkg::FS_CMP, 1'b0, 1'b0, 4'd11, 4'd12, 3'b000, 2'd0);
      addRecord(isaPkg::FMT_I, ctlPkg::FS_DADD, 1'b1, 1'b0, 4'd13, 4'd14, 3'b000, 2'd0);
      addRecord(isaPkg::FMT_I, ctlPkg::FS_BIT, 1'b0, 1'b1, 4'd15, 4'd1, 3'b000, 2'd0);
      addRecord(isaPkg::FMT_I, ctlPkg::FS_BIC, 1'b1, 1'b0, 4'd2, 4'd3, 3'b000, 2'd0);
      addRecord(isaPkg::FMT_I, ctlPkg::FS_BIS, 1'b1, 1'b0, 4'd4, 4'd5, 3'b000, 2'd0);
      addRecord(isaPkg::FMT_I, ctlPkg::FS_XOR, 1'b1, 1'b0, 4'd6, 4'd7, 3'b000, 2'd0);
      addRecord(isaPkg::FMT_I, ctlPkg::FS_AND, 1'b1, 1'b0, 4'd8, 4'd9, 3'b000, 2'd0);
      // Format II, no source register
      addRecord(isaPkg::FMT_II, ctlPkg::FS_RRC, 1'b1, 1'b0, 4'd0, 4'd4, 3'b000, 2'd0);
      addRecord(isaPkg::FMT_II, ctlPkg::FS_SWPB, 1'b1, 1'b0, 4'd0, 4'd5, 3'b000, 2'd0);
      addRecord(isaPkg::FMT_II, ctlPkg::FS_RRA, 1'b1, 1'b1, 4'd0, 4'd6, 3'b000, 2'd0);
      addRecord(isaPkg::FMT_II, ctlPkg::FS_SXT, 1'b1, 1'b0, 4'd0, 4'd7, 3'b010, 2'd0);
      addRecord(isaPkg::FMT_II, ctlPkg::FS_PUSH, 1'b1, 1'b0, 4'd0, 4'd8, 3'b000, 2'd0);
      addRecord(isaPkg::FMT_II, ctlPkg::FS_CALL, 1'b1, 1'b0, 4'd0, 4'd9, 3'b001, 2'd1);
      addExt(16'h1234);
      addRecord(isaPkg::FMT_II, ctlPkg::FS_RETI, 1'b1, 1'b0, 4'd0, 4'd0, 3'b000, 2'd0);
      // Extension counts; indexed to indexed takes two words
      addRecord(isaPkg::FMT_I, ctlPkg::FS_MOV, 1'b1, 1'b0, 4'd5, 4'd6, 3'b101, 2'd2);
      addExt(16'h0002);
      addExt(16'h0004);
      addRecord(isaPkg::FMT_I, ctlPkg::FS_MOV, 1'b1, 1'b0, 4'd0, 4'd7, 3'b011, 2'd1);
      addExt(16'hBEEF);
      addRecord(isaPkg::FMT_I, ctlPkg::FS_ADD, 1'b1, 1'b0, 4'd5, 4'd6, 3'b011, 2'd0);
      addRecord(isaPkg::FMT_I, ctlPkg::FS_SUB, 1'b1, 1'b0, 4'd4, 4'd9, 3'b100, 2'd1);
      addExt(16'h0006);
      addRecord(isaPkg::FMT_I, ctlPkg::FS_AND, 1'b1, 1'b0, 4'd3, 4'd2, 3'b110, 2'd1);
      addExt(16'h0008);
      addRecord(isaPkg::FMT_I, ctlPkg::FS_XOR, 1'b1, 1'b0, 4'd1, 4'd3, 3'b001, 2'd1);
      addExt(16'h0010);
      addRecord(isaPkg::FMT_NONE, ctlPkg::FS_NONE, 1'b0, 1'b0, 4'd0, 4'd0, 3'b000, 2'd0);
      // Jumps, condition as fs
      addRecord(isaPkg::FMT_J, 6'd7, 1'b0, 1'b0, 4'd0, 4'd0, 3'b000, 2'd0);
      addTarget(16'h004A);
      addRecord(isaPkg::FMT_J, 6'd0, 1'b0, 1'b0, 4'd0, 4'd0, 3'b000, 2'd0);
      addTarget(16'h005A);
      addRecord(isaPkg::FMT_I, ctlPkg::FS_CMP, 1'b0, 1'b1, 4'd2, 4'd3, 3'b000, 2'd0);
      addRecord(isaPkg::FMT_J, 6'd3, 1'b0, 1'b0, 4'd0, 4'd0, 3'b000, 2'd0);
      addTarget(16'h0050);
      addRecord(isaPkg::FMT_II, ctlPkg::FS_RRC, 1'b1, 1'b1, 4'd0, 4'd1, 3'b000, 2'd0);
      addRecord(isaPkg::FMT_J, 6'd7, 1'b0, 1'b0, 4'd0, 4'd0, 3'b000, 2'd0);
      addTarget(16'h0052);

      // Pass 0 without hold, pass 1 repeats under random hold
      for (pass = 0; pass < 2; pass++)
      begin
         holdRandom = (pass == 1);
         reset = 1'b1;
         repeat (10) nextCycle();
         reset = 1'b0;
         for (r = 0; r < recCount; r++)
            inspectRecord(r);
      end
      $display("STATUS: PASS");
      $finish;
   end

endmodule

`default_nettype wire
